// File: filelist.f
hdl/core_pkg.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
verification/core_tb.sv

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int WORD_W     = 32;
  localparam int INSTR_W    = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ALU_OP_W   = 4;
  localparam int IMM_SEL_W  = 2;
  localparam int NUM_REGS   = 32;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [INSTR_W-1:0]    instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [ALU_OP_W-1:0]   alu_op_t;
  typedef logic [IMM_SEL_W-1:0]  imm_sel_t;

  // LA32 reset vector
  localparam word_t RESET_PC = 32'h1C00_0000;
  localparam word_t PC_STEP  = 32'd4;

  // alu operations
  localparam alu_op_t ALU_NOP  = 4'd0;
  localparam alu_op_t ALU_ADD  = 4'd1;
  localparam alu_op_t ALU_SUB  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_AND  = 4'd5;
  localparam alu_op_t ALU_OR   = 4'd6;
  localparam alu_op_t ALU_XOR  = 4'd7;
  localparam alu_op_t ALU_SLL  = 4'd8;
  localparam alu_op_t ALU_SRL  = 4'd9;
  localparam alu_op_t ALU_SRA  = 4'd10;

  // second operand source
  localparam imm_sel_t IMM_NONE = 2'd0;
  localparam imm_sel_t IMM_SI12 = 2'd1;
  localparam imm_sel_t IMM_UI5  = 2'd2;
  localparam imm_sel_t IMM_SI20 = 2'd3;

  // register-register, instr[31:15]
  localparam logic [16:0] OP_ADD_W  = 17'h00020;
  localparam logic [16:0] OP_SUB_W  = 17'h00022;
  localparam logic [16:0] OP_SLT    = 17'h00024;
  localparam logic [16:0] OP_SLTU   = 17'h00025;
  localparam logic [16:0] OP_AND    = 17'h00029;
  localparam logic [16:0] OP_OR     = 17'h0002A;
  localparam logic [16:0] OP_XOR    = 17'h0002B;
  localparam logic [16:0] OP_SLL_W  = 17'h0002E;
  localparam logic [16:0] OP_SRL_W  = 17'h0002F;
  localparam logic [16:0] OP_SRA_W  = 17'h00030;

  // shift by ui5, also instr[31:15]
  localparam logic [16:0] OP_SLLI_W = 17'h00081;
  localparam logic [16:0] OP_SRLI_W = 17'h00089;
  localparam logic [16:0] OP_SRAI_W = 17'h00091;

  // instr[31:22]
  localparam logic [9:0]  OP_ADDI_W  = 10'h00A;
  // instr[31:25]
  localparam logic [6:0]  OP_LU12I_W = 7'h0A;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    alu_op_t   alu_op;
    word_t     src1;
    word_t     src2;
    reg_addr_t rd;
    logic      wen;
  } dec_to_exe_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    logic      wen;
    word_t     result;
  } exe_to_wb_t;

  // execute result seen by decode in the same cycle
  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
    word_t     data;
  } fwd_t;

endpackage

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
  input  wire         aclk,
  input  wire         arst_n_i,
  input  wire         instr_valid_i,
  input  wire instr_t instr_i,
  output logic        wb_valid_o,
  output word_t       wb_pc_o,
  output logic        wb_rf_wen_o,
  output reg_addr_t   wb_rf_wnum_o,
  output word_t       wb_rf_wdata_o
);

  dec_to_exe_t dec;
  exe_to_wb_t  exe;
  fwd_t        exe_fwd;
  reg_addr_t   rj_addr;
  reg_addr_t   rk_addr;
  word_t       rj_data;
  word_t       rk_data;

  decode_stage i_decode (
    .aclk          (aclk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .exe_fwd_i     (exe_fwd),
    .rj_addr_o     (rj_addr),
    .rk_addr_o     (rk_addr),
    .rj_data_i     (rj_data),
    .rk_data_i     (rk_data),
    .dec_o         (dec)
  );

  execute_stage i_execute (
    .aclk      (aclk),
    .arst_n_i  (arst_n_i),
    .dec_i     (dec),
    .exe_fwd_o (exe_fwd),
    .exe_o     (exe)
  );

  writeback_stage i_writeback (
    .aclk          (aclk),
    .arst_n_i      (arst_n_i),
    .exe_i         (exe),
    .rj_addr_i     (rj_addr),
    .rk_addr_i     (rk_addr),
    .rj_data_o     (rj_data),
    .rk_data_o     (rk_data),
    .wb_valid_o    (wb_valid_o),
    .wb_pc_o       (wb_pc_o),
    .wb_rf_wen_o   (wb_rf_wen_o),
    .wb_rf_wnum_o  (wb_rf_wnum_o),
    .wb_rf_wdata_o (wb_rf_wdata_o)
  );

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*; (
  input  wire         aclk,
  input  wire         arst_n_i,
  input  wire         instr_valid_i,
  input  wire instr_t instr_i,
  input  wire fwd_t   exe_fwd_i,
  output reg_addr_t   rj_addr_o,
  output reg_addr_t   rk_addr_o,
  input  wire word_t  rj_data_i,
  input  wire word_t  rk_data_i,
  output dec_to_exe_t dec_o
);

  logic        ir_valid;
  instr_t      ir_instr;
  word_t       ir_pc;
  word_t       pc_cnt;

  reg_addr_t   rd;
  reg_addr_t   rj;
  reg_addr_t   rk;
  logic [16:0] op17;
  logic [9:0]  op10;
  logic [6:0]  op7;

  alu_op_t     alu_op;
  imm_sel_t    imm_sel;
  logic        src1_zero;
  word_t       imm;
  word_t       rj_val;
  word_t       rk_val;
  dec_to_exe_t dec_d;

  // pc only advances on accepted instructions
  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ir_valid <= 1'b0;
      ir_instr <= '0;
      ir_pc    <= RESET_PC;
      pc_cnt   <= RESET_PC;
    end else begin
      ir_valid <= instr_valid_i;
      if (instr_valid_i) begin
        ir_instr <= instr_i;
        ir_pc    <= pc_cnt;
        pc_cnt   <= pc_cnt + PC_STEP;
      end
    end
  end

  assign rd   = ir_instr[4:0];
  assign rj   = ir_instr[9:5];
  assign rk   = ir_instr[14:10];
  assign op17 = ir_instr[31:15];
  assign op10 = ir_instr[31:22];
  assign op7  = ir_instr[31:25];

  assign rj_addr_o = rj;
  assign rk_addr_o = rk;

  // opcode tables
  always_comb begin
    alu_op    = ALU_NOP;
    imm_sel   = IMM_NONE;
    src1_zero = 1'b0;
    if (op10 == OP_ADDI_W) begin
      alu_op  = ALU_ADD;
      imm_sel = IMM_SI12;
    end else if (op7 == OP_LU12I_W) begin
      // upper immediate added to zero
      alu_op    = ALU_ADD;
      imm_sel   = IMM_SI20;
      src1_zero = 1'b1;
    end else begin
      case (op17)
        OP_ADD_W:  alu_op = ALU_ADD;
        OP_SUB_W:  alu_op = ALU_SUB;
        OP_SLT:    alu_op = ALU_SLT;
        OP_SLTU:   alu_op = ALU_SLTU;
        OP_AND:    alu_op = ALU_AND;
        OP_OR:     alu_op = ALU_OR;
        OP_XOR:    alu_op = ALU_XOR;
        OP_SLL_W:  alu_op = ALU_SLL;
        OP_SRL_W:  alu_op = ALU_SRL;
        OP_SRA_W:  alu_op = ALU_SRA;
        OP_SLLI_W: begin
          alu_op  = ALU_SLL;
          imm_sel = IMM_UI5;
        end
        OP_SRLI_W: begin
          alu_op  = ALU_SRL;
          imm_sel = IMM_UI5;
        end
        OP_SRAI_W: begin
          alu_op  = ALU_SRA;
          imm_sel = IMM_UI5;
        end
        default:   alu_op = ALU_NOP;
      endcase
    end
  end

  always_comb begin
    case (imm_sel)
      IMM_SI12: imm = {{20{ir_instr[21]}}, ir_instr[21:10]};
      IMM_UI5:  imm = {27'd0, ir_instr[14:10]};
      IMM_SI20: imm = {ir_instr[24:5], 12'd0};
      default:  imm = '0;
    endcase
  end

  // distance one comes from execute, longer distances from the register file
  assign rj_val = (exe_fwd_i.wen && exe_fwd_i.rd == rj && rj != '0) ?
                  exe_fwd_i.data : rj_data_i;
  assign rk_val = (exe_fwd_i.wen && exe_fwd_i.rd == rk && rk != '0) ?
                  exe_fwd_i.data : rk_data_i;

  always_comb begin
    dec_d.valid  = ir_valid;
    dec_d.pc     = ir_pc;
    dec_d.alu_op = alu_op;
    dec_d.src1   = src1_zero ? '0 : rj_val;
    dec_d.src2   = (imm_sel == IMM_NONE) ? rk_val : imm;
    dec_d.rd     = rd;
    // unknown opcodes still flow down as a valid no-op
    dec_d.wen    = ir_valid && (alu_op != ALU_NOP) && (rd != '0);
  end

  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_o <= '0;
    end else begin
      dec_o <= dec_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
  input  wire              aclk,
  input  wire              arst_n_i,
  input  wire dec_to_exe_t dec_i,
  output fwd_t             exe_fwd_o,
  output exe_to_wb_t       exe_o
);

  logic [4:0] shamt;
  word_t      result;
  logic       wen;

  assign shamt = dec_i.src2[4:0];
  assign wen   = dec_i.valid & dec_i.wen;

  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD:  result = dec_i.src1 + dec_i.src2;
      ALU_SUB:  result = dec_i.src1 - dec_i.src2;
      ALU_SLT: begin
        result = '0;
        result[0] = $signed(dec_i.src1) < $signed(dec_i.src2);
      end
      ALU_SLTU: begin
        result = '0;
        result[0] = dec_i.src1 < dec_i.src2;
      end
      ALU_AND:  result = dec_i.src1 & dec_i.src2;
      ALU_OR:   result = dec_i.src1 | dec_i.src2;
      ALU_XOR:  result = dec_i.src1 ^ dec_i.src2;
      ALU_SLL:  result = dec_i.src1 << shamt;
      ALU_SRL:  result = dec_i.src1 >> shamt;
      // sign fill
      ALU_SRA:  result = $unsigned($signed(dec_i.src1) >>> shamt);
      default:  result = '0;
    endcase
  end

  // same-cycle path back to decode
  always_comb begin
    exe_fwd_o.wen  = wen;
    exe_fwd_o.rd   = dec_i.rd;
    exe_fwd_o.data = result;
  end

  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exe_o <= '0;
    end else begin
      exe_o.valid  <= dec_i.valid;
      exe_o.pc     <= dec_i.pc;
      exe_o.rd     <= dec_i.rd;
      exe_o.wen    <= wen;
      exe_o.result <= result;
    end
  end

endmodule

`default_nettype wire

// File: hdl/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import core_pkg::*; (
  input  wire             aclk,
  input  wire             arst_n_i,
  input  wire exe_to_wb_t exe_i,
  input  wire reg_addr_t  rj_addr_i,
  input  wire reg_addr_t  rk_addr_i,
  output word_t           rj_data_o,
  output word_t           rk_data_o,
  output logic            wb_valid_o,
  output word_t           wb_pc_o,
  output logic            wb_rf_wen_o,
  output reg_addr_t       wb_rf_wnum_o,
  output word_t           wb_rf_wdata_o
);

  word_t rf [NUM_REGS];
  logic  wb_wen;

  // exe_i is the registered write-back item, visible for one cycle
  assign wb_wen = exe_i.valid & exe_i.wen & (exe_i.rd != '0);

  // r0 reads zero, pending write wins over the array
  function automatic word_t read_port(input reg_addr_t addr);
    word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (wb_wen && exe_i.rd == addr) begin
      data = exe_i.result;
    end else begin
      data = rf[addr];
    end
    return data;
  endfunction

  always_comb begin
    rj_data_o = read_port(rj_addr_i);
    rk_data_o = read_port(rk_addr_i);
  end

  // array updates at the end of the write-back cycle
  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (wb_wen) begin
      rf[exe_i.rd] <= exe_i.result;
    end
  end

  // debug view
  assign wb_valid_o    = exe_i.valid;
  assign wb_pc_o       = exe_i.pc;
  assign wb_rf_wen_o   = wb_wen;
  assign wb_rf_wnum_o  = exe_i.rd;
  assign wb_rf_wdata_o = exe_i.result;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build core_tb with Verilator, run it and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module core_tb -o core_sim &&
  ./obj_dir/core_sim > sim.log 2>&1 ||
  echo "build or simulation ended with an error"
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

  localparam word_t FIRST_PC = 32'h1C00_0000;

  typedef struct packed {
    instr_t     instr;
    logic       wen;
    reg_addr_t  rd;
    word_t      data;
    logic [3:0] idle;
  } entry_t;

  typedef struct packed {
    word_t     pc;
    logic      wen;
    reg_addr_t rd;
    word_t     data;
    int        cycle;
  } exp_t;

  logic      aclk;
  logic      arst_n_i;
  logic      instr_valid_i;
  instr_t    instr_i;
  logic      wb_valid_o;
  word_t     wb_pc_o;
  logic      wb_rf_wen_o;
  reg_addr_t wb_rf_wnum_o;
  word_t     wb_rf_wdata_o;

  entry_t tbl[$];
  exp_t   exp_q[$];
  word_t  model_rf [NUM_REGS];
  word_t  next_pc;
  int     cyc = 0;

  // register-register ops first, then the ui5 shifts
  logic [16:0] op_tbl [13] = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR,
                               OP_SLL_W, OP_SRL_W, OP_SRA_W, OP_SLLI_W, OP_SRLI_W, OP_SRAI_W};

  core_top i_dut (
    .aclk          (aclk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_pc_o       (wb_pc_o),
    .wb_rf_wen_o   (wb_rf_wen_o),
    .wb_rf_wnum_o  (wb_rf_wnum_o),
    .wb_rf_wdata_o (wb_rf_wdata_o)
  );

  always #2 aclk = ~aclk;
  always @(posedge aclk) cyc <= cyc + 1;

  task automatic stop_on_fail();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_on_fail();
    end
  endtask

  // outputs are sampled mid-cycle, away from the driving edge
  always @(negedge aclk) begin
    exp_t e;
    if (arst_n_i && !wb_valid_o) begin
      check_val("wb_rf_wen_o", {31'd0, wb_rf_wen_o}, 32'd0);
    end else if (arst_n_i) begin
      assert (exp_q.size() != 0) else begin
        $display("write-back at %0t ns with no instruction in flight", $time);
        stop_on_fail();
      end
      e = exp_q.pop_front();
      // presented in cycle c, retired in cycle c+3
      check_val("write-back cycle", word_t'(cyc), word_t'(e.cycle + 3));
      check_val("wb_pc_o", wb_pc_o, e.pc);
      check_val("wb_rf_wen_o", {31'd0, wb_rf_wen_o}, {31'd0, e.wen});
      if (e.wen) begin
        check_val("wb_rf_wnum_o", {27'd0, wb_rf_wnum_o}, {27'd0, e.rd});
        check_val("wb_rf_wdata_o", wb_rf_wdata_o, e.data);
      end
    end
  end

  // k follows the order of op_tbl
  function automatic word_t model_alu(input int k, input word_t a, input word_t b);
    case (k)
      0: return a + b;
      1: return a - b;
      2: return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      3: return {31'd0, a < b};
      4: return a & b;
      5: return a | b;
      6: return a ^ b;
      7: return a << b[4:0];
      8: return a >> b[4:0];
      default: return a[31] ? ~(~a >> b[4:0]) : a >> b[4:0];
    endcase
  endfunction

  task automatic issue(input instr_t ins, input logic wen, input reg_addr_t rd,
                       input word_t data);
    exp_t e;
    @(posedge aclk);
    instr_valid_i <= 1'b1;
    instr_i       <= ins;
    e.pc    = next_pc;
    e.wen   = wen;
    e.rd    = rd;
    e.data  = data;
    e.cycle = cyc + 1;
    exp_q.push_back(e);
    next_pc = next_pc + 32'd4;
    if (wen) begin
      model_rf[rd] = data;
    end
  endtask

  // idle cycles carry junk on instr_i
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge aclk);
      instr_valid_i <= 1'b0;
      instr_i       <= 32'($urandom);
    end
  endtask

  task automatic add_entry(input instr_t ins, input logic wen, input reg_addr_t rd,
                           input word_t data, input logic [3:0] idle_before);
    tbl.push_back({ins, wen, rd, data, idle_before});
  endtask

  initial begin
    int        seed;
    int        k;
    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    logic [11:0] imm;
    word_t     b;
    word_t     res;
    instr_t    ins;
    seed = $urandom(45);
    aclk          = 1'b0;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    next_pc       = FIRST_PC;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_rf[i] = '0;
    end
    add_entry({OP_LU12I_W, 20'h80000, 5'd1}, 1'b1, 5'd1, 32'h8000_0000, 4'd0);
    add_entry({OP_ADDI_W, 12'hFFF, 5'd0, 5'd2}, 1'b1, 5'd2, 32'hFFFF_FFFF, 4'd0);
    add_entry({OP_ADDI_W, 12'h005, 5'd0, 5'd3}, 1'b1, 5'd3, 32'h0000_0005, 4'd0);
    add_entry({OP_ADDI_W, 12'h7FF, 5'd0, 5'd4}, 1'b1, 5'd4, 32'h0000_07FF, 4'd0);
    add_entry({OP_ADD_W, 5'd4, 5'd3, 5'd5}, 1'b1, 5'd5, 32'h0000_0804, 4'd0);
    add_entry({OP_SUB_W, 5'd4, 5'd3, 5'd6}, 1'b1, 5'd6, 32'hFFFF_F806, 4'd0);
    add_entry({OP_SLT, 5'd3, 5'd1, 5'd7}, 1'b1, 5'd7, 32'h0000_0001, 4'd0);
    add_entry({OP_SLTU, 5'd3, 5'd1, 5'd8}, 1'b1, 5'd8, 32'h0000_0000, 4'd0);
    add_entry({OP_SLT, 5'd2, 5'd3, 5'd9}, 1'b1, 5'd9, 32'h0000_0000, 4'd0);
    add_entry({OP_SLTU, 5'd2, 5'd3, 5'd10}, 1'b1, 5'd10, 32'h0000_0001, 4'd0);
    add_entry({OP_AND, 5'd4, 5'd2, 5'd11}, 1'b1, 5'd11, 32'h0000_07FF, 4'd0);
    add_entry({OP_OR, 5'd3, 5'd1, 5'd12}, 1'b1, 5'd12, 32'h8000_0005, 4'd0);
    add_entry({OP_XOR, 5'd4, 5'd2, 5'd13}, 1'b1, 5'd13, 32'hFFFF_F800, 4'd0);
    add_entry({OP_SLL_W, 5'd4, 5'd3, 5'd14}, 1'b1, 5'd14, 32'h8000_0000, 4'd0);
    add_entry({OP_SRL_W, 5'd3, 5'd1, 5'd15}, 1'b1, 5'd15, 32'h0400_0000, 4'd0);
    add_entry({OP_SRA_W, 5'd3, 5'd1, 5'd16}, 1'b1, 5'd16, 32'hFC00_0000, 4'd0);
    add_entry({OP_SRAI_W, 5'd4, 5'd12, 5'd17}, 1'b1, 5'd17, 32'hF800_0000, 4'd0);
    add_entry({OP_SRLI_W, 5'd4, 5'd12, 5'd18}, 1'b1, 5'd18, 32'h0800_0000, 4'd0);
    add_entry({OP_SLLI_W, 5'd3, 5'd3, 5'd19}, 1'b1, 5'd19, 32'h0000_0028, 4'd0);
    add_entry({OP_ADDI_W, 12'h800, 5'd4, 5'd20}, 1'b1, 5'd20, 32'hFFFF_FFFF, 4'd0);
    // r0 write and unknown opcode retire without a register write
    add_entry({OP_ADDI_W, 12'h007, 5'd3, 5'd0}, 1'b0, 5'd0, 32'h0000_0000, 4'd3);
    add_entry({OP_ADD_W, 5'd3, 5'd0, 5'd21}, 1'b1, 5'd21, 32'h0000_0005, 4'd0);
    add_entry(32'hFFFF_FFE5, 1'b0, 5'd5, 32'h0000_0000, 4'd1);
    add_entry({OP_ADD_W, 5'd5, 5'd0, 5'd22}, 1'b1, 5'd22, 32'h0000_0804, 4'd0);
    // dependency distances one, two and three
    add_entry({OP_ADDI_W, 12'd100, 5'd0, 5'd23}, 1'b1, 5'd23, 32'h0000_0064, 4'd0);
    add_entry({OP_ADDI_W, 12'd1, 5'd23, 5'd24}, 1'b1, 5'd24, 32'h0000_0065, 4'd0);
    add_entry({OP_ADD_W, 5'd24, 5'd23, 5'd25}, 1'b1, 5'd25, 32'h0000_00C9, 4'd0);
    add_entry({OP_ADD_W, 5'd25, 5'd23, 5'd26}, 1'b1, 5'd26, 32'h0000_012D, 4'd0);
    add_entry({OP_ADD_W, 5'd26, 5'd26, 5'd27}, 1'b1, 5'd27, 32'h0000_025A, 4'd2);
    add_entry({OP_LU12I_W, 20'h12345, 5'd28}, 1'b1, 5'd28, 32'h1234_5000, 4'd0);
    add_entry({OP_ADDI_W, 12'h678, 5'd28, 5'd28}, 1'b1, 5'd28, 32'h1234_5678, 4'd0);

    repeat (4) @(posedge aclk);
    arst_n_i <= 1'b1;
    idle(2);
    foreach (tbl[i]) begin
      idle(int'(tbl[i].idle));
      issue(tbl[i].instr, tbl[i].wen, tbl[i].rd, tbl[i].data);
    end

    // random mix on r0..r7 so that most instructions depend on recent ones
    for (int n = 0; n < 400; n++) begin
      k  = int'($urandom % 14);
      rd = reg_addr_t'($urandom % 8);
      rj = reg_addr_t'($urandom % 8);
      rk = reg_addr_t'($urandom % 8);
      if (k == 13) begin
        imm = 12'($urandom);
        ins = {OP_ADDI_W, imm, rj, rd};
        res = model_rf[rj] + {{20{imm[11]}}, imm};
      end else begin
        ins = {op_tbl[k], rk, rj, rd};
        b   = (k >= 10) ? {27'd0, rk} : model_rf[rk];
        res = model_alu((k >= 10) ? k - 3 : k, model_rf[rj], b);
      end
      if ($urandom % 8 == 0) begin
        idle(1 + int'($urandom % 3));
      end
      issue(ins, rd != '0, rd, res);
    end
    idle(1);

    for (int w = 0; w < 20 && exp_q.size() != 0; w++) begin
      @(posedge aclk);
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d write-backs never arrived", exp_q.size());
      stop_on_fail();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire
